// ==== Bender.yml ====
package:
  name: ingress_adapt

sources:
  - files:
      - ingress_adapt_pkg.sv
      - ingress_frame_fifo.sv
      - ingress_counters.sv
      - ingress_gate.sv
      - ingress_width_conv.sv
      - ingress_port_array_adapt.sv
  - target: test
    files:
      - ingress_adapt_tb.sv

// ==== ingress_adapt.f ====
ingress_adapt_pkg.sv
ingress_frame_fifo.sv
ingress_counters.sv
ingress_gate.sv
ingress_width_conv.sv
ingress_port_array_adapt.sv
ingress_adapt_tb.sv

// ==== ingress_adapt_pkg.sv ====
// Ingress adapter shared definitions
// FSM state encodings and counter slot indices for the per-port lanes

package ingress_adapt_pkg;

    ////////////////////
    // FSM states

    // Frame-boundary enable gate
    typedef enum logic [1:0] {
        GATE_MUTED,
        GATE_PASS,
        GATE_SKIP
    } gate_state_t;

    // Frame-atomic buffer admission
    typedef enum logic [1:0] {
        FIFO_IDLE,
        FIFO_ACCEPT,
        FIFO_DISCARD
    } fifo_state_t;

    ////////////////////
    // Profile counters

    typedef enum logic [1:0] {
        CNT_FRAMES = 2'd0,
        CNT_BYTES  = 2'd1,
        CNT_DROPS  = 2'd2
    } cnt_idx_t;

    // One slot per cnt_idx_t entry
    localparam int NUM_CNTS = int'(CNT_DROPS) + 1;

endpackage

// ==== ingress_adapt_tb.sv ====
// Ingress port array adapter testbench
// Random frames on every port, scoreboard of expected frames, counter and gate checks

`timescale 1ns/1ps

module ingress_adapt_tb;
    import ingress_adapt_pkg::*;

    localparam int NUM_PORTS       = 2;
    localparam int IN_BYTES        = 1;
    localparam int CONV_BYTES      = 4;
    localparam int FIFO_DEPTH      = 16;
    localparam int MAX_FRAME_WORDS = 8;
    localparam int COUNT_WIDTH     = 16;
    localparam int IN_W            = IN_BYTES * 8;
    localparam int OUT_W           = CONV_BYTES * 8;
    // All phases take about 4000 cycles and this leaves a wide margin
    localparam int CYCLE_LIMIT     = 20000;
    localparam int FRAME_SLOTS     = 1024;
    localparam int RX_MAX          = 64;
    // out_tready patterns
    localparam logic [1:0] READY_HIGH = 2'd0;
    localparam logic [1:0] READY_RAND = 2'd1;
    localparam logic [1:0] READY_LOW  = 2'd2;

    logic                                       clk;
    logic                                       rst;
    logic [NUM_PORTS-1:0]                       in_tvalid;
    logic [NUM_PORTS*IN_W-1:0]                  in_tdata;
    logic [NUM_PORTS-1:0]                       in_tlast;
    logic [NUM_PORTS-1:0]                       out_tvalid;
    logic [NUM_PORTS-1:0]                       out_tready;
    logic [NUM_PORTS*OUT_W-1:0]                 out_tdata;
    logic [NUM_PORTS*CONV_BYTES-1:0]            out_tkeep;
    logic [NUM_PORTS-1:0]                       out_tlast;
    logic [NUM_PORTS-1:0]                       port_enable;
    logic [NUM_PORTS-1:0]                       cnt_clear;
    logic [NUM_PORTS-1:0]                       connected;
    logic [NUM_PORTS-1:0]                       buf_full_drop;
    logic [NUM_PORTS*NUM_CNTS*COUNT_WIDTH-1:0]  cnts;

    integer     seed;
    logic [1:0] ready_mode;
    int         errors;
    int         checks;
    int         cycles;

    ////////////////////
    // Scoreboard state

    // Frames sent while the port was enabled
    logic [7:0] frame_byte [NUM_PORTS][FRAME_SLOTS*MAX_FRAME_WORDS];
    int         frame_len  [NUM_PORTS][FRAME_SLOTS];
    int         wr_frm     [NUM_PORTS];
    int         rd_frm     [NUM_PORTS];
    int         missing    [NUM_PORTS];
    int         drops_total[NUM_PORTS];
    // Expected counter values since the last clear
    int         mdl_frames [NUM_PORTS];
    int         mdl_bytes  [NUM_PORTS];
    int         mdl_drops  [NUM_PORTS];
    // Frame being collected from the output
    logic [7:0] rx_buf     [NUM_PORTS][RX_MAX];
    int         rx_len     [NUM_PORTS];
    // Output values seen during a stall
    logic                  hold_pend [NUM_PORTS];
    logic [OUT_W-1:0]      hold_data [NUM_PORTS];
    logic [CONV_BYTES-1:0] hold_keep [NUM_PORTS];
    logic                  hold_last [NUM_PORTS];

    ingress_port_array_adapt #(
        .NUM_PORTS(NUM_PORTS), .IN_BYTES(IN_BYTES), .CONV_BYTES(CONV_BYTES),
        .FIFO_DEPTH(FIFO_DEPTH), .MAX_FRAME_WORDS(MAX_FRAME_WORDS), .COUNT_WIDTH(COUNT_WIDTH)
    ) ingress_port_array_adapt_i (
        .clk(clk), .rst(rst),
        .in_tvalid(in_tvalid), .in_tdata(in_tdata), .in_tlast(in_tlast),
        .out_tvalid(out_tvalid), .out_tready(out_tready), .out_tdata(out_tdata),
        .out_tkeep(out_tkeep), .out_tlast(out_tlast),
        .port_enable(port_enable), .cnt_clear(cnt_clear),
        .connected(connected), .buf_full_drop(buf_full_drop), .cnts(cnts)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////
    // Stimulus helpers

    // Random frames on one port that are recorded only while it is enabled
    task automatic run_port(input int p, input int nframes, input int min_gap);
        int         f;
        int         k;
        int         len;
        int         gap;
        logic [7:0] b;
        bit         record;
        record = port_enable[p];
        for (f = 0; f < nframes; f++) begin
            len = 1 + {$random(seed)} % MAX_FRAME_WORDS;
            gap = min_gap + {$random(seed)} % 4;
            for (k = 0; k < len; k++) begin
                b = $random(seed);
                @(posedge clk);
                in_tvalid[p]           <= 1'b1;
                in_tdata[p*IN_W +: 8]  <= b;
                in_tlast[p]            <= (k == len - 1);
                if (record) begin
                    frame_byte[p][wr_frm[p]*MAX_FRAME_WORDS + k] = b;
                end
            end
            if (record) begin
                frame_len[p][wr_frm[p]] = len;
                wr_frm[p]++;
            end
            repeat (gap) begin
                @(posedge clk);
                in_tvalid[p] <= 1'b0;
                in_tlast[p]  <= 1'b0;
            end
        end
        @(posedge clk);
        in_tvalid[p] <= 1'b0;
        in_tlast[p]  <= 1'b0;
    endtask

    // Both ports at once
    task automatic run_all(input int nframes, input int min_gap);
        fork
            run_port(0, nframes, min_gap);
            run_port(1, nframes, min_gap);
        join
    endtask

    // Lanes idle and drained for n cycles in a row
    task automatic wait_quiet(input int n);
        int q;
        q = 0;
        while (q < n) begin
            @(posedge clk);
            if (out_tvalid == '0 && in_tvalid == '0) begin
                q++;
            end else begin
                q = 0;
            end
        end
    endtask

    ////////////////////
    // Checkers

    function automatic bit frame_matches(input int p, input int idx);
        int b;
        if (frame_len[p][idx] != rx_len[p]) begin
            return 1'b0;
        end
        for (b = 0; b < rx_len[p]; b++) begin
            if (frame_byte[p][idx*MAX_FRAME_WORDS + b] != rx_buf[p][b]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    // Compare a finished output frame with the oldest frame still expected
    task automatic close_frame(input int p, input logic [CONV_BYTES-1:0] keep);
        int                    idx;
        int                    len;
        int                    b;
        logic [CONV_BYTES-1:0] exp_keep;
        // Skip frames the buffer reported as dropped
        while (rd_frm[p] < wr_frm[p] && missing[p] < drops_total[p] &&
               !frame_matches(p, rd_frm[p])) begin
            missing[p]++;
            rd_frm[p]++;
        end
        checks++;
        if (rd_frm[p] >= wr_frm[p]) begin
            errors++;
            $display("Port %0d delivered a frame of %0d bytes that was never sent",
                     p, rx_len[p]);
        end else begin
            idx = rd_frm[p];
            len = frame_len[p][idx];
            if (rx_len[p] != len) begin
                errors++;
                $display("Error: port %0d out_tlast after 0x%h bytes, expected 0x%h",
                         p, rx_len[p], len);
            end
            for (b = 0; b < len && b < rx_len[p] && b < RX_MAX; b++) begin
                checks++;
                if (rx_buf[p][b] != frame_byte[p][idx*MAX_FRAME_WORDS + b]) begin
                    errors++;
                    $display(
                        "Error: port %0d out_tdata frame %0d byte %0d got 0x%h expected 0x%h",
                        p, idx, b, rx_buf[p][b], frame_byte[p][idx*MAX_FRAME_WORDS + b]);
                end
            end
            // Final beat keeps only the remainder from lane 0 up
            exp_keep = CONV_BYTES'((1 << ((len - 1) % CONV_BYTES + 1)) - 1);
            checks++;
            if (keep != exp_keep) begin
                errors++;
                $display("Error: port %0d out_tkeep got 0x%h expected 0x%h", p, keep, exp_keep);
            end
            rd_frm[p]++;
            mdl_frames[p]++;
            mdl_bytes[p] += len;
        end
        rx_len[p] = 0;
    endtask

    // One transferred output beat
    task automatic take_beat(input int p);
        logic [OUT_W-1:0]      data;
        logic [CONV_BYTES-1:0] keep;
        int                    b;
        data = out_tdata[p*OUT_W +: OUT_W];
        keep = out_tkeep[p*CONV_BYTES +: CONV_BYTES];
        for (b = 0; b < CONV_BYTES; b++) begin
            if (keep[b]) begin
                if (rx_len[p] < RX_MAX) begin
                    rx_buf[p][rx_len[p]] = data[b*8 +: 8];
                end
                rx_len[p]++;
            end else begin
                checks++;
                if (data[b*8 +: 8] != 8'h00) begin
                    errors++;
                    $display("Error: port %0d out_tdata lane %0d got 0x%h expected 0x00",
                             p, b, data[b*8 +: 8]);
                end
            end
        end
        if (out_tlast[p]) begin
            close_frame(p, keep);
        end else begin
            checks++;
            if (keep != '1) begin
                errors++;
                $display("Error: port %0d out_tkeep got 0x%h expected 0x%h",
                         p, keep, {CONV_BYTES{1'b1}});
            end
        end
    endtask

    task automatic check_counts();
        logic [COUNT_WIDTH-1:0] got;
        int                     exp_val;
        int                     p;
        int                     c;
        for (p = 0; p < NUM_PORTS; p++) begin
            for (c = 0; c < NUM_CNTS; c++) begin
                got = cnts[(p*NUM_CNTS + c)*COUNT_WIDTH +: COUNT_WIDTH];
                case (cnt_idx_t'(c))
                    CNT_FRAMES: exp_val = mdl_frames[p];
                    CNT_BYTES:  exp_val = mdl_bytes[p];
                    default:    exp_val = mdl_drops[p];
                endcase
                checks++;
                if (got != COUNT_WIDTH'(exp_val)) begin
                    errors++;
                    $display("Error: port %0d cnts[%0d] got 0x%h expected 0x%h",
                             p, c, got, COUNT_WIDTH'(exp_val));
                end
            end
            // Every frame not delivered must match one drop pulse
            checks++;
            if (missing[p] + wr_frm[p] - rd_frm[p] != drops_total[p]) begin
                errors++;
                $display("Port %0d lost %0d frames but reported %0d drops", p,
                         missing[p] + wr_frm[p] - rd_frm[p], drops_total[p]);
            end
        end
    endtask

    task automatic check_connected(input logic [NUM_PORTS-1:0] expected);
        checks++;
        if (connected != expected) begin
            errors++;
            $display("Error: connected got 0x%h expected 0x%h", connected, expected);
        end
    endtask

    ////////////////////
    // Output monitor

    always @(posedge clk) begin
        int p;
        if (!rst) begin
            for (p = 0; p < NUM_PORTS; p++) begin
                // Drop pulses come before any later frame reaches the output
                if (buf_full_drop[p]) begin
                    drops_total[p]++;
                    mdl_drops[p]++;
                end
                if (hold_pend[p]) begin
                    checks++;
                    if (!out_tvalid[p]) begin
                        errors++;
                        $display("Port %0d withdrew out_tvalid before the transfer", p);
                    end
                    if (out_tdata[p*OUT_W +: OUT_W] != hold_data[p]) begin
                        errors++;
                        $display("Error: port %0d out_tdata got 0x%h held 0x%h",
                                 p, out_tdata[p*OUT_W +: OUT_W], hold_data[p]);
                    end
                    if (out_tkeep[p*CONV_BYTES +: CONV_BYTES] != hold_keep[p]) begin
                        errors++;
                        $display("Error: port %0d out_tkeep got 0x%h held 0x%h",
                                 p, out_tkeep[p*CONV_BYTES +: CONV_BYTES], hold_keep[p]);
                    end
                    if (out_tlast[p] != hold_last[p]) begin
                        errors++;
                        $display("Error: port %0d out_tlast got 0x%h held 0x%h",
                                 p, out_tlast[p], hold_last[p]);
                    end
                end
                hold_pend[p] = out_tvalid[p] && !out_tready[p];
                hold_data[p] = out_tdata[p*OUT_W +: OUT_W];
                hold_keep[p] = out_tkeep[p*CONV_BYTES +: CONV_BYTES];
                hold_last[p] = out_tlast[p];
                if (out_tvalid[p] && out_tready[p]) begin
                    take_beat(p);
                end
            end
        end
    end

    // out_tready pattern
    always @(posedge clk) begin
        case (ready_mode)
            READY_HIGH: out_tready <= '1;
            READY_RAND: out_tready <= NUM_PORTS'($random(seed));
            default:    out_tready <= '0;
        endcase
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks %0d, errors %0d", checks, errors);
            $display("*** FAILED ***");
            $finish;
        end
    end

    ////////////////////
    // Test sequence

    initial begin
        seed        = 9;
        rst         = 1'b1;
        in_tvalid   = '0;
        in_tdata    = '0;
        in_tlast    = '0;
        out_tready  = '1;
        port_enable = '0;
        cnt_clear   = '0;
        ready_mode  = READY_HIGH;
        errors      = 0;
        checks      = 0;
        cycles      = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            wr_frm[p]      = 0;
            rd_frm[p]      = 0;
            missing[p]     = 0;
            drops_total[p] = 0;
            mdl_frames[p]  = 0;
            mdl_bytes[p]   = 0;
            mdl_drops[p]   = 0;
            rx_len[p]      = 0;
            hold_pend[p]   = 1'b0;
        end
        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        // Reset state
        checks++;
        if (out_tvalid != '0 || buf_full_drop != '0 || cnts != '0) begin
            errors++;
            $display("Error: out_tvalid 0x%h buf_full_drop 0x%h cnts 0x%h, expected all zero",
                     out_tvalid, buf_full_drop, cnts);
        end
        check_connected('0);
        port_enable <= '1;
        repeat (3) @(posedge clk);
        check_connected('1);

        // Plain data path without back-pressure
        run_all(150, 2);
        wait_quiet(40);
        checks++;
        if (drops_total[0] != 0 || drops_total[1] != 0) begin
            errors++;
            $display("Buffer dropped frames although out_tready stayed high");
        end
        check_counts();

        // Port 1 switched off between frames
        port_enable[1] <= 1'b0;
        repeat (3) @(posedge clk);
        check_connected(2'b01);
        run_all(60, 2);
        wait_quiet(40);
        check_connected(2'b01);
        check_counts();
        port_enable[1] <= 1'b1;
        repeat (3) @(posedge clk);
        check_connected(2'b11);

        // Random back-pressure
        ready_mode <= READY_RAND;
        run_all(100, 2);
        ready_mode <= READY_HIGH;
        wait_quiet(40);
        check_counts();

        // Bursts into a stalled output
        repeat (8) begin
            ready_mode <= READY_LOW;
            run_all(5, 0);
            repeat (10) @(posedge clk);
            ready_mode <= READY_HIGH;
            wait_quiet(40);
        end
        checks++;
        if (drops_total[0] + drops_total[1] == 0) begin
            errors++;
            $display("No buffer drops seen during the stalled bursts");
        end
        check_counts();

        // Counter clear reads zero two cycles after the pulse
        cnt_clear <= '1;
        @(posedge clk);
        cnt_clear <= '0;
        @(posedge clk);
        for (int p = 0; p < NUM_PORTS; p++) begin
            mdl_frames[p] = 0;
            mdl_bytes[p]  = 0;
            mdl_drops[p]  = 0;
        end
        check_counts();

        // Counting again after the clear
        run_all(40, 2);
        wait_quiet(40);
        check_counts();

        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== ingress_counters.sv ====
// Ingress profile counters
// Saturating frame, byte and drop counts for one port

`timescale 1ns/1ps

module ingress_counters #(
    parameter int IN_BYTES    = 1,
    parameter int COUNT_WIDTH = 16
) (
    input  logic clk,
    input  logic rst,
    input  logic enable,
    input  logic clear_stb,
    input  logic mon_tvalid,
    input  logic mon_tready,
    input  logic mon_tlast,
    input  logic drop_stb,
    output logic [ingress_adapt_pkg::NUM_CNTS-1:0][COUNT_WIDTH-1:0] counts
);
    import ingress_adapt_pkg::*;

    localparam int SUM_W = COUNT_WIDTH + 1;

    logic mon_xfer;

    // Add with clamp at all ones
    function automatic logic [COUNT_WIDTH-1:0] sat_add(
        input logic [COUNT_WIDTH-1:0] base,
        input int unsigned            incr
    );
        logic [SUM_W-1:0] sum;
        sum = {1'b0, base} + SUM_W'(incr);
        return sum[COUNT_WIDTH] ? '1 : sum[COUNT_WIDTH-1:0];
    endfunction

    // Monitor only, a beat counts when the link moves it
    assign mon_xfer = mon_tvalid && mon_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            counts <= '0;
        end else if (clear_stb) begin
            // Clear wins over any increment this cycle
            counts <= '0;
        end else begin
            if (enable && mon_xfer) begin
                counts[CNT_BYTES] <= sat_add(counts[CNT_BYTES], IN_BYTES);
                if (mon_tlast) begin
                    counts[CNT_FRAMES] <= sat_add(counts[CNT_FRAMES], 1);
                end
            end
            // Drops are counted even while disabled
            if (drop_stb) begin
                counts[CNT_DROPS] <= sat_add(counts[CNT_DROPS], 1);
            end
        end
    end

endmodule

// ==== ingress_frame_fifo.sv ====
// Ingress frame buffer
// Admits or discards whole frames on a port that cannot be stalled

`timescale 1ns/1ps

module ingress_frame_fifo #(
    parameter int IN_BYTES        = 1,
    parameter int FIFO_DEPTH      = 16,
    parameter int MAX_FRAME_WORDS = 8
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  in_tvalid,
    input  logic [IN_BYTES*8-1:0] in_tdata,
    input  logic                  in_tlast,
    output logic                  fifo_tvalid,
    output logic [IN_BYTES*8-1:0] fifo_tdata,
    output logic                  fifo_tlast,
    input  logic                  fifo_tready,
    output logic                  buf_full_drop
);
    import ingress_adapt_pkg::*;

    localparam int PTR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W  = $clog2(FIFO_DEPTH + 1);
    localparam int BEAT_W = $clog2(MAX_FRAME_WORDS + 1);

    // Storage, no reset on payload
    logic [IN_BYTES*8-1:0] mem_data [FIFO_DEPTH];
    logic                  mem_last [FIFO_DEPTH];

    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  fill_cnt;
    logic [BEAT_W-1:0] frame_beats;
    fifo_state_t       state;

    logic has_room;
    logic wr_en;
    logic rd_en;
    logic drop_start;

    ////////////////////
    // Admission

    // Room for a worst-case frame, judged at the first beat only
    assign has_room   = (FIFO_DEPTH - int'(fill_cnt)) >= MAX_FRAME_WORDS;
    assign wr_en      = in_tvalid && ((state == FIFO_ACCEPT) ||
                                      (state == FIFO_IDLE && has_room));
    assign drop_start = in_tvalid && (state == FIFO_IDLE) && !has_room;
    assign rd_en      = fifo_tvalid && fifo_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state         <= FIFO_IDLE;
            buf_full_drop <= 1'b0;
            frame_beats   <= '0;
        end else begin
            buf_full_drop <= drop_start;
            case (state)
                FIFO_IDLE: begin
                    // Single-beat frames never leave idle
                    if (in_tvalid && !in_tlast) begin
                        state <= has_room ? FIFO_ACCEPT : FIFO_DISCARD;
                    end
                end
                default: begin
                    if (in_tvalid && in_tlast) begin
                        state <= FIFO_IDLE;
                    end
                end
            endcase
            // Beats written so far in this frame
            if (wr_en) begin
                frame_beats <= in_tlast ? '0 : frame_beats + 1'b1;
            end
        end
    end

    ////////////////////
    // Circular buffer

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem_data[wr_ptr] <= in_tdata;
            mem_last[wr_ptr] <= in_tlast;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fill_cnt <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            fill_cnt <= fill_cnt + CNT_W'(wr_en) - CNT_W'(rd_en);
        end
    end

    // Word shows up the cycle after its write
    assign fifo_tvalid = (fill_cnt != '0);
    assign fifo_tdata  = mem_data[rd_ptr];
    assign fifo_tlast  = mem_last[rd_ptr];

    // Admission check must keep every admitted frame inside the buffer
    a_no_write_when_full: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> fill_cnt < CNT_W'(FIFO_DEPTH));

    a_frame_within_max: assert property (@(posedge clk) disable iff (rst)
        wr_en |-> frame_beats < BEAT_W'(MAX_FRAME_WORDS));

endmodule

// ==== ingress_gate.sv ====
// Ingress port enable gate
// Opens and closes only between frames and reports the connected state

`timescale 1ns/1ps

module ingress_gate #(
    parameter int IN_BYTES = 1
) (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  enable,
    input  logic                  fifo_tvalid,
    input  logic [IN_BYTES*8-1:0] fifo_tdata,
    input  logic                  fifo_tlast,
    output logic                  fifo_tready,
    output logic                  gated_tvalid,
    output logic [IN_BYTES*8-1:0] gated_tdata,
    output logic                  gated_tlast,
    input  logic                  gated_tready,
    output logic                  connected
);
    import ingress_adapt_pkg::*;

    gate_state_t state;
    logic        in_frame;
    logic        xfer;
    logic        frame_open_next;
    logic        beat_waiting;

    assign xfer = fifo_tvalid && fifo_tready;
    // Whether a frame is still open after this cycle
    assign frame_open_next = in_frame ? !(xfer && fifo_tlast) : (xfer && !fifo_tlast);
    // Beat already offered downstream but not taken
    assign beat_waiting = fifo_tvalid && !fifo_tready;

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= GATE_MUTED;
            in_frame <= 1'b0;
        end else begin
            in_frame <= frame_open_next;
            case (state)
                GATE_MUTED: begin
                    // Late enable skips the rest of the frame
                    if (enable) begin
                        state <= frame_open_next ? GATE_SKIP : GATE_PASS;
                    end
                end
                GATE_PASS: begin
                    if (!enable && !frame_open_next && !beat_waiting) begin
                        state <= GATE_MUTED;
                    end
                end
                default: begin
                    if (xfer && fifo_tlast) begin
                        state <= enable ? GATE_PASS : GATE_MUTED;
                    end
                end
            endcase
        end
    end

    // Forward in pass, sink everything otherwise
    assign gated_tvalid = (state == GATE_PASS) && fifo_tvalid;
    assign gated_tdata  = fifo_tdata;
    assign gated_tlast  = fifo_tlast;
    assign fifo_tready  = (state == GATE_PASS) ? gated_tready : 1'b1;
    assign connected    = (state == GATE_PASS);

    // An offered beat keeps the gate open until it is taken
    a_valid_only_in_pass: assert property (@(posedge clk) disable iff (rst)
        gated_tvalid && !gated_tready |=> gated_tvalid && state == GATE_PASS);

endmodule

// ==== ingress_port_array_adapt.sv ====
// Ingress port array adapter
// One lane per port of frame buffer, counters, enable gate and upsizer

`timescale 1ns/1ps

module ingress_port_array_adapt #(
    parameter int NUM_PORTS       = 2,
    parameter int IN_BYTES        = 1,
    parameter int CONV_BYTES      = 4,
    parameter int FIFO_DEPTH      = 16,
    parameter int MAX_FRAME_WORDS = 8,
    parameter int COUNT_WIDTH     = 16
) (
    input  logic                              clk,
    input  logic                              rst,
    // Narrow ingress ports, no back-pressure
    input  logic [NUM_PORTS-1:0]              in_tvalid,
    input  logic [NUM_PORTS*IN_BYTES*8-1:0]   in_tdata,
    input  logic [NUM_PORTS-1:0]              in_tlast,
    // Converged ports towards the router
    output logic [NUM_PORTS-1:0]              out_tvalid,
    input  logic [NUM_PORTS-1:0]              out_tready,
    output logic [NUM_PORTS*CONV_BYTES*8-1:0] out_tdata,
    output logic [NUM_PORTS*CONV_BYTES-1:0]   out_tkeep,
    output logic [NUM_PORTS-1:0]              out_tlast,
    // Control and status
    input  logic [NUM_PORTS-1:0]              port_enable,
    input  logic [NUM_PORTS-1:0]              cnt_clear,
    output logic [NUM_PORTS-1:0]              connected,
    output logic [NUM_PORTS-1:0]              buf_full_drop,
    output logic [NUM_PORTS*ingress_adapt_pkg::NUM_CNTS*COUNT_WIDTH-1:0] cnts
);
    import ingress_adapt_pkg::*;

    localparam int IN_W  = IN_BYTES * 8;
    localparam int OUT_W = CONV_BYTES * 8;
    localparam int CNT_W = NUM_CNTS * COUNT_WIDTH;

    for (genvar p = 0; p < NUM_PORTS; p++) begin : g_lane
        // Buffer to gate
        logic            fifo_tvalid;
        logic [IN_W-1:0] fifo_tdata;
        logic            fifo_tlast;
        logic            fifo_tready;
        // Gate to converter
        logic            gated_tvalid;
        logic [IN_W-1:0] gated_tdata;
        logic            gated_tlast;
        logic            gated_tready;

        ingress_frame_fifo #(
            .IN_BYTES(IN_BYTES), .FIFO_DEPTH(FIFO_DEPTH), .MAX_FRAME_WORDS(MAX_FRAME_WORDS)
        ) frame_fifo_i (
            .clk(clk), .rst(rst),
            .in_tvalid(in_tvalid[p]), .in_tdata(in_tdata[p*IN_W +: IN_W]),
            .in_tlast(in_tlast[p]),
            .fifo_tvalid(fifo_tvalid), .fifo_tdata(fifo_tdata),
            .fifo_tlast(fifo_tlast), .fifo_tready(fifo_tready),
            .buf_full_drop(buf_full_drop[p])
        );

        // Watches the buffer output link, never drives ready
        ingress_counters #(
            .IN_BYTES(IN_BYTES), .COUNT_WIDTH(COUNT_WIDTH)
        ) counters_i (
            .clk(clk), .rst(rst), .enable(port_enable[p]), .clear_stb(cnt_clear[p]),
            .mon_tvalid(fifo_tvalid), .mon_tready(fifo_tready), .mon_tlast(fifo_tlast),
            .drop_stb(buf_full_drop[p]), .counts(cnts[p*CNT_W +: CNT_W])
        );

        ingress_gate #(
            .IN_BYTES(IN_BYTES)
        ) gate_i (
            .clk(clk), .rst(rst), .enable(port_enable[p]),
            .fifo_tvalid(fifo_tvalid), .fifo_tdata(fifo_tdata),
            .fifo_tlast(fifo_tlast), .fifo_tready(fifo_tready),
            .gated_tvalid(gated_tvalid), .gated_tdata(gated_tdata),
            .gated_tlast(gated_tlast), .gated_tready(gated_tready),
            .connected(connected[p])
        );

        ingress_width_conv #(
            .IN_BYTES(IN_BYTES), .CONV_BYTES(CONV_BYTES)
        ) width_conv_i (
            .clk(clk), .rst(rst),
            .gated_tvalid(gated_tvalid), .gated_tdata(gated_tdata),
            .gated_tlast(gated_tlast), .gated_tready(gated_tready),
            .out_tvalid(out_tvalid[p]), .out_tdata(out_tdata[p*OUT_W +: OUT_W]),
            .out_tkeep(out_tkeep[p*CONV_BYTES +: CONV_BYTES]),
            .out_tlast(out_tlast[p]), .out_tready(out_tready[p])
        );
    end

endmodule

// ==== ingress_width_conv.sv ====
// Ingress width converter
// Packs narrow input beats into wide output beats with a keep mask

`timescale 1ns/1ps

module ingress_width_conv #(
    parameter int IN_BYTES   = 1,
    parameter int CONV_BYTES = 4
) (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    gated_tvalid,
    input  logic [IN_BYTES*8-1:0]   gated_tdata,
    input  logic                    gated_tlast,
    output logic                    gated_tready,
    output logic                    out_tvalid,
    output logic [CONV_BYTES*8-1:0] out_tdata,
    output logic [CONV_BYTES-1:0]   out_tkeep,
    output logic                    out_tlast,
    input  logic                    out_tready
);

    localparam int RATIO  = CONV_BYTES / IN_BYTES;
    localparam int SLOT_W = (RATIO > 1) ? $clog2(RATIO) : 1;

    if (CONV_BYTES % IN_BYTES != 0) begin : g_ratio_check
        $error("CONV_BYTES must be a multiple of IN_BYTES");
    end

    logic [SLOT_W-1:0]       slot;
    logic [CONV_BYTES*8-1:0] acc_data;
    logic [CONV_BYTES-1:0]   acc_keep;
    logic [CONV_BYTES*8-1:0] merged_data;
    logic [CONV_BYTES-1:0]   merged_keep;
    logic                    in_xfer;
    logic                    out_xfer;
    logic                    beat_final;

    ////////////////////
    // Handshake

    // Hold off input while a packed beat is stuck
    assign gated_tready = !out_tvalid || out_tready;
    assign in_xfer      = gated_tvalid && gated_tready;
    assign out_xfer     = out_tvalid && out_tready;
    assign beat_final   = (slot == SLOT_W'(RATIO - 1)) || gated_tlast;

    ////////////////////
    // Packing

    always_comb begin
        // Fresh word starts from zero so unused lanes stay clear
        merged_data = (slot == '0) ? '0 : acc_data;
        merged_keep = (slot == '0) ? '0 : acc_keep;
        merged_data[slot*IN_BYTES*8 +: IN_BYTES*8] = gated_tdata;
        merged_keep[slot*IN_BYTES +: IN_BYTES]     = '1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot       <= '0;
            out_tvalid <= 1'b0;
        end else begin
            if (out_xfer) begin
                out_tvalid <= 1'b0;
            end
            if (in_xfer) begin
                if (beat_final) begin
                    slot       <= '0;
                    out_tvalid <= 1'b1;
                end else begin
                    slot <= slot + 1'b1;
                end
            end
        end
    end

    // Accumulator and output holding register
    always_ff @(posedge clk) begin
        if (in_xfer) begin
            acc_data <= merged_data;
            acc_keep <= merged_keep;
            if (beat_final) begin
                out_tdata <= merged_data;
                out_tkeep <= merged_keep;
                out_tlast <= gated_tlast;
            end
        end
    end

    // Keep fills lanes from 0 up and only a last beat may be short
    a_keep_packed: assert property (@(posedge clk) disable iff (rst)
        out_tvalid |-> out_tkeep[0] && ((out_tkeep & (out_tkeep + 1'b1)) == '0) &&
                       (out_tlast || out_tkeep == '1));

endmodule
